/* all.f */
+incdir+include
design/e300_cfg_pkg.sv
design/e300_sample_pkg.sv
design/mode_strobe_gen.sv
design/rx_deinterleave.sv
design/tx_interleave.sv
design/e300_io_top.sv
tests/tb_e300_io.sv

/* design/e300_cfg_pkg.sv */
// Sizing and mode constants shared by all blocks; the mode bit must be synchronized before use
`default_nettype none

package e300_cfg_pkg;

   // ----------------------------------------------------------
   // Sample sizing
   // ----------------------------------------------------------

   // Width of one I or Q sample on the converter bus
   localparam int sample_width = 12;

   // ----------------------------------------------------------
   // Mode control
   // ----------------------------------------------------------

   // Flops in the mode bit synchronizer
   // At least two, more only adds latency to a mode change
   localparam int sync_stages = 2;

   // Values of the synchronized mode bit
   // Single channel, one word per cycle
   localparam logic mode_siso = 1'b0;
   // Two channels interleaved, frame bit marks channel 1
   localparam logic mode_mimo = 1'b1;

endpackage : e300_cfg_pkg

`default_nettype wire

/* design/e300_io_top.sv */
// Sample-path top; takes the de-serialized word pair and gives both frame halves, no clock cells
`default_nettype none
`timescale 1ns/100ps

module e300_io_top (
   input  wire logic                                  siso_clk2,
   input  wire logic                                  arst_n_i,
   // Mode request, 1 selects two channels
   input  wire logic                                  mimo_i,

   // Converter receive side
   input  wire logic                                  rx_frame_i,
   input  wire logic [e300_cfg_pkg::sample_width-1:0] rx_i_i,
   input  wire logic [e300_cfg_pkg::sample_width-1:0] rx_q_i,

   // Baseband transmit channels
   input  wire logic [e300_cfg_pkg::sample_width-1:0] tx_i0_i,
   input  wire logic [e300_cfg_pkg::sample_width-1:0] tx_q0_i,
   input  wire logic [e300_cfg_pkg::sample_width-1:0] tx_i1_i,
   input  wire logic [e300_cfg_pkg::sample_width-1:0] tx_q1_i,

   // Baseband receive channels
   output logic      [e300_cfg_pkg::sample_width-1:0] rx_i0_o,
   output logic      [e300_cfg_pkg::sample_width-1:0] rx_q0_o,
   output logic      [e300_cfg_pkg::sample_width-1:0] rx_i1_o,
   output logic      [e300_cfg_pkg::sample_width-1:0] rx_q1_o,

   // Converter transmit side
   output logic      [e300_cfg_pkg::sample_width-1:0] tx_i_o,
   output logic      [e300_cfg_pkg::sample_width-1:0] tx_q_o,

   // Clock enable for the radio logic, stands in for radio_clk
   output logic                                       radio_en_o,
   output logic                                       tx_frame_hi_o,
   output logic                                       tx_frame_lo_o
);

   import e300_sample_pkg::*;

   // ----------------------------------------------------------
   // Shared mode and strobe
   // ----------------------------------------------------------

   logic mimo;
   logic strobe;

   mode_strobe_gen mode_strobe_gen_i (
      .siso_clk2 (siso_clk2),
      .arst_n_i  (arst_n_i),
      .mimo_i    (mimo_i),
      .mimo_o    (mimo),
      .strobe_o  (strobe)
   );

   // Radio logic runs on the strobe cycles only
   assign radio_en_o = strobe;

   // ----------------------------------------------------------
   // Receive path
   // ----------------------------------------------------------

   iq_t rx_word;
   iq_t rx_ch0;
   iq_t rx_ch1;

   assign rx_word = '{i: rx_i_i, q: rx_q_i};

   rx_deinterleave rx_deinterleave_i (
      .siso_clk2  (siso_clk2),
      .arst_n_i   (arst_n_i),
      .mimo_i     (mimo),
      .strobe_i   (strobe),
      .rx_frame_i (rx_frame_i),
      .rx_word_i  (rx_word),
      .rx_ch0_o   (rx_ch0),
      .rx_ch1_o   (rx_ch1)
   );

   assign rx_i0_o = rx_ch0.i;
   assign rx_q0_o = rx_ch0.q;
   assign rx_i1_o = rx_ch1.i;
   assign rx_q1_o = rx_ch1.q;

   // ----------------------------------------------------------
   // Transmit path
   // ----------------------------------------------------------

   iq_t tx_ch0;
   iq_t tx_ch1;
   iq_t tx_word;

   assign tx_ch0 = '{i: tx_i0_i, q: tx_q0_i};
   assign tx_ch1 = '{i: tx_i1_i, q: tx_q1_i};

   tx_interleave tx_interleave_i (
      .siso_clk2     (siso_clk2),
      .arst_n_i      (arst_n_i),
      .mimo_i        (mimo),
      .strobe_i      (strobe),
      .tx_ch0_i      (tx_ch0),
      .tx_ch1_i      (tx_ch1),
      .tx_word_o     (tx_word),
      .tx_frame_hi_o (tx_frame_hi_o),
      .tx_frame_lo_o (tx_frame_lo_o)
   );

   assign tx_i_o = tx_word.i;
   assign tx_q_o = tx_word.q;

endmodule : e300_io_top

`default_nettype wire

/* design/e300_sample_pkg.sv */
// Sample and I/Q pair types; samples carry no sign so users must interpret two's complement
`default_nettype none

package e300_sample_pkg;

   import e300_cfg_pkg::*;

   // ----------------------------------------------------------
   // Sample types
   // ----------------------------------------------------------

   // One raw converter sample
   // Sign is left to the user, the datapath only moves bits
   typedef logic [sample_width-1:0] sample_t;

   // One complex sample
   // I sits in the upper half, Q in the lower half
   // 24 bits for the default sample width
   typedef struct packed {
      // In-phase component
      sample_t i;
      // Quadrature component
      sample_t q;
   } iq_t;

   // Word on the converter side carries one channel per cycle
   // Channel outputs carry one iq_t each
   // Same type on both sides keeps the steering logic plain

endpackage : e300_sample_pkg

`default_nettype wire

/* design/mode_strobe_gen.sv */
// Mode synchronizer and sample strobe; mimo_i may be asynchronous, strobe is valid 2 cycles later
`default_nettype none
`timescale 1ns/100ps

module mode_strobe_gen (
   input  wire logic siso_clk2,
   input  wire logic arst_n_i,
   // Raw mode request from another clock domain
   input  wire logic mimo_i,
   // Synchronized mode
   output logic      mimo_o,
   // One cycle in two in MIMO, every cycle in SISO
   output logic      strobe_o
);

   import e300_cfg_pkg::*;

   // ----------------------------------------------------------
   // Mode synchronizer
   // ----------------------------------------------------------

   // Shift chain, newest bit at index 0
   logic [sync_stages-1:0] sync_q;

   always_ff @(posedge siso_clk2 or negedge arst_n_i) begin
      if (!arst_n_i) begin
         sync_q <= '0;
      end else begin
         sync_q <= {sync_q[sync_stages-2:0], mimo_i};
      end
   end

   // Last stage is the mode seen by the datapath
   assign mimo_o = sync_q[sync_stages-1];

   // ----------------------------------------------------------
   // Sample strobe
   // ----------------------------------------------------------

   // Phase of the half-rate radio clock
   // Held at zero in SISO so MIMO always starts on a strobe
   logic phase_q;

   always_ff @(posedge siso_clk2 or negedge arst_n_i) begin
      if (!arst_n_i) begin
         phase_q <= 1'b0;
      end else if (mimo_o) begin
         phase_q <= ~phase_q;
      end else begin
         phase_q <= 1'b0;
      end
   end

   // Strobe marks the first cycle of each radio clock period
   always_comb begin
      if (mimo_o) begin
         strobe_o = ~phase_q;
      end else begin
         strobe_o = 1'b1;
      end
   end

   // ----------------------------------------------------------
   // Checks
   // ----------------------------------------------------------

   // In steady MIMO the strobe never repeats on back-to-back cycles
   strobe_alternates_a : assert property (
      @(posedge siso_clk2) disable iff (!arst_n_i)
      (mimo_o && strobe_o) ##1 mimo_o |-> !strobe_o
   );

endmodule : mode_strobe_gen

`default_nettype wire

/* design/rx_deinterleave.sv */
// Receive demux; in MIMO the frame bit must alternate 1 then 0 or channel 1 repeats stale data
`default_nettype none
`timescale 1ns/100ps

module rx_deinterleave (
   input  wire logic                  siso_clk2,
   input  wire logic                  arst_n_i,
   // Synchronized mode and sample strobe
   input  wire logic                  mimo_i,
   input  wire logic                  strobe_i,
   // Frame bit, high marks a channel 1 word
   input  wire logic                  rx_frame_i,
   // De-serialized word from the converter bus
   input  wire e300_sample_pkg::iq_t  rx_word_i,
   // Channel outputs, stable for one strobe period
   output e300_sample_pkg::iq_t       rx_ch0_o,
   output e300_sample_pkg::iq_t       rx_ch1_o
);

   import e300_cfg_pkg::*;
   import e300_sample_pkg::*;

   // ----------------------------------------------------------
   // Stage 1 demux
   // ----------------------------------------------------------

   // Channel 1 word waiting for its channel 0 partner
   iq_t hold_q;
   // Demuxed channel pair
   iq_t ch0_q;
   iq_t ch1_q;

   // Channel 1 arrives first in each MIMO pair
   always_ff @(posedge siso_clk2 or negedge arst_n_i) begin
      if (!arst_n_i) begin
         hold_q <= '0;
      end else if (mimo_i == mode_mimo && rx_frame_i) begin
         hold_q <= rx_word_i;
      end
   end

   always_ff @(posedge siso_clk2 or negedge arst_n_i) begin
      if (!arst_n_i) begin
         ch0_q <= '0;
         ch1_q <= '0;
      end else if (mimo_i == mode_siso) begin
         // Same stream on both channels
         // Lets either downstream DDC take the single channel
         ch0_q <= rx_word_i;
         ch1_q <= rx_word_i;
      end else if (!rx_frame_i) begin
         // Frame 0 closes the pair
         ch0_q <= rx_word_i;
         ch1_q <= hold_q;
      end
   end

   // ----------------------------------------------------------
   // Stage 2 output register
   // ----------------------------------------------------------

   // Loads once per radio clock period
   // In SISO the strobe is always high so this is a plain delay
   always_ff @(posedge siso_clk2 or negedge arst_n_i) begin
      if (!arst_n_i) begin
         rx_ch0_o <= '0;
         rx_ch1_o <= '0;
      end else if (strobe_i) begin
         rx_ch0_o <= ch0_q;
         rx_ch1_o <= ch1_q;
      end
   end

   // ----------------------------------------------------------
   // Checks
   // ----------------------------------------------------------

   // After three SISO cycles both stages hold duplicated data
   siso_channels_equal_a : assert property (
      @(posedge siso_clk2) disable iff (!arst_n_i)
      (mimo_i == mode_siso) [*3] |-> (rx_ch0_o == rx_ch1_o)
   );

endmodule : rx_deinterleave

`default_nettype wire

/* design/tx_interleave.sv */
// Transmit mux; in SISO a zero sample on channel 0 is treated as idle and channel 1 is sent
`default_nettype none
`timescale 1ns/100ps

module tx_interleave (
   input  wire logic                  siso_clk2,
   input  wire logic                  arst_n_i,
   // Synchronized mode and sample strobe
   input  wire logic                  mimo_i,
   input  wire logic                  strobe_i,
   // Channel inputs, sampled on strobe cycles
   input  wire e300_sample_pkg::iq_t  tx_ch0_i,
   input  wire e300_sample_pkg::iq_t  tx_ch1_i,
   // Word toward the converter bus
   output e300_sample_pkg::iq_t       tx_word_o,
   // Frame halves for the DDR frame pin
   output logic                       tx_frame_hi_o,
   output logic                       tx_frame_lo_o
);

   import e300_cfg_pkg::*;
   import e300_sample_pkg::*;

   // ----------------------------------------------------------
   // SISO channel select
   // ----------------------------------------------------------

   // Per component fallback
   // Either DUC may drive the single channel, useful for loopback
   iq_t siso_word;

   always_comb begin
      siso_word.i = (tx_ch0_i.i != '0) ? tx_ch0_i.i : tx_ch1_i.i;
      siso_word.q = (tx_ch0_i.q != '0) ? tx_ch0_i.q : tx_ch1_i.q;
   end

   // ----------------------------------------------------------
   // Interleave
   // ----------------------------------------------------------

   // Channel 0 held for the second half of the pair
   iq_t hold_q;

   always_ff @(posedge siso_clk2 or negedge arst_n_i) begin
      if (!arst_n_i) begin
         tx_word_o <= '0;
         hold_q    <= '0;
      end else if (strobe_i) begin
         // Channel 1 goes out first in MIMO
         if (mimo_i == mode_mimo) begin
            tx_word_o <= tx_ch1_i;
         end else begin
            tx_word_o <= siso_word;
         end
         hold_q <= tx_ch0_i;
      end else begin
         tx_word_o <= hold_q;
      end
   end

   // ----------------------------------------------------------
   // Frame pair
   // ----------------------------------------------------------

   // Strobe aligned with the word it marks
   logic strobe_d_q;

   always_ff @(posedge siso_clk2 or negedge arst_n_i) begin
      if (!arst_n_i) begin
         strobe_d_q <= 1'b0;
      end else begin
         strobe_d_q <= strobe_i;
      end
   end

   // High half every word in SISO
   assign tx_frame_hi_o = strobe_d_q;
   // Low half only in MIMO, gives a frame two words long
   assign tx_frame_lo_o = strobe_d_q & mimo_i;

   // ----------------------------------------------------------
   // Checks
   // ----------------------------------------------------------

   // Settled SISO sends a SISO frame on every word
   siso_frame_a : assert property (
      @(posedge siso_clk2) disable iff (!arst_n_i)
      !mimo_i ##1 !mimo_i |-> tx_frame_hi_o && !tx_frame_lo_o
   );

endmodule : tx_interleave

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# Builds the sample-path testbench with Verilator, runs it and scans the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f all.f --top-module tb_e300_io -o tb_e300_io \
   && ./obj_dir/tb_e300_io > sim.log 2>&1 \
   || echo "test failed" >> sim.log

cat sim.log

grep -q "test failed" sim.log \
   && { echo "Simulation reported failure"; exit 1; } \
   || { echo "Simulation clean"; exit 0; }

/* include/e300_io_model.svh */
// Cycle model of the sample path; call model_step once per rising edge with that cycle's inputs
`ifndef E300_IO_MODEL_SVH
`define E300_IO_MODEL_SVH

// ----------------------------------------------------------
// Model state, one variable per DUT register
// ----------------------------------------------------------

logic [1:0]           m_sync;
logic                 m_phase;
e300_sample_pkg::iq_t m_rx_hold;
e300_sample_pkg::iq_t m_rx_s1_ch0;
e300_sample_pkg::iq_t m_rx_s1_ch1;
e300_sample_pkg::iq_t m_rx_ch0;
e300_sample_pkg::iq_t m_rx_ch1;
e300_sample_pkg::iq_t m_tx_word;
e300_sample_pkg::iq_t m_tx_hold;
logic                 m_strobe_d;
int                   model_fail_cnt = 0;

// Clear everything, same as the asynchronous reset
task automatic model_reset();
   m_sync      = '0;
   m_phase     = 1'b0;
   m_rx_hold   = '0;
   m_rx_s1_ch0 = '0;
   m_rx_s1_ch1 = '0;
   m_rx_ch0    = '0;
   m_rx_ch1    = '0;
   m_tx_word   = '0;
   m_tx_hold   = '0;
   m_strobe_d  = 1'b0;
endtask

// Strobe as seen by the DUT during the current cycle
function automatic logic model_strobe();
   return m_sync[1] ? ~m_phase : 1'b1;
endfunction

// Advance one rising edge
task automatic model_step(input logic mimo_in, input logic frame_in,
                          input e300_sample_pkg::iq_t rx_in,
                          input e300_sample_pkg::iq_t tx0_in,
                          input e300_sample_pkg::iq_t tx1_in);
   logic mimo;
   logic strobe;
   mimo   = m_sync[1];
   strobe = model_strobe();
   // Output stage reads the old stage 1
   if (strobe) begin
      m_rx_ch0 = m_rx_s1_ch0;
      m_rx_ch1 = m_rx_s1_ch1;
   end
   if (!mimo) begin
      m_rx_s1_ch0 = rx_in;
      m_rx_s1_ch1 = rx_in;
   end else if (frame_in) begin
      m_rx_hold = rx_in;
   end else begin
      m_rx_s1_ch0 = rx_in;
      m_rx_s1_ch1 = m_rx_hold;
   end
   // Transmit word reads the old hold
   if (strobe) begin
      m_tx_word   = mimo ? tx1_in : tx0_in;
      m_tx_word.i = (!mimo && tx0_in.i == '0) ? tx1_in.i : m_tx_word.i;
      m_tx_word.q = (!mimo && tx0_in.q == '0) ? tx1_in.q : m_tx_word.q;
      m_tx_hold   = tx0_in;
   end else begin
      m_tx_word = m_tx_hold;
   end
   m_strobe_d = strobe;
   m_phase    = mimo ? ~m_phase : 1'b0;
   m_sync     = {m_sync[0], mimo_in};
endtask

// Compare one signal and count a mismatch
task automatic model_expect(input string name, input logic [31:0] exp,
                            input logic [31:0] act);
   assert (exp === act) else begin
      $display("[FAIL] %s expected %h actual %h", name, exp, act);
      model_fail_cnt++;
   end
endtask

`endif

/* tests/tb_e300_io.sv */
// Random sample-path testbench; DUT is checked at falling edges against a cycle model
`default_nettype none
`timescale 1ns/100ps

module tb_e300_io;

   import e300_sample_pkg::*;

   // ----------------------------------------------------------
   // Run length and clocking
   // ----------------------------------------------------------

   localparam int clk_period  = 40;
   localparam int reset_len   = 8;
   localparam int num_tests   = 5;
   localparam int test_cycles = 2000;
   // Test kinds
   localparam int siso_rx     = 0;
   localparam int mimo_rx     = 1;
   localparam int siso_tx     = 2;
   localparam int mimo_tx     = 3;
   localparam int mode_switch = 4;

   logic   siso_clk2;
   logic   arst_n_i;
   logic   mimo_i;
   logic   rx_frame_i;
   iq_t    rx_word;
   iq_t    tx0;
   iq_t    tx1;
   logic   [e300_cfg_pkg::sample_width-1:0] rx_i0_o;
   logic   [e300_cfg_pkg::sample_width-1:0] rx_q0_o;
   logic   [e300_cfg_pkg::sample_width-1:0] rx_i1_o;
   logic   [e300_cfg_pkg::sample_width-1:0] rx_q1_o;
   logic   [e300_cfg_pkg::sample_width-1:0] tx_i_o;
   logic   [e300_cfg_pkg::sample_width-1:0] tx_q_o;
   logic   radio_en_o;
   logic   tx_frame_hi_o;
   logic   tx_frame_lo_o;
   integer seed = 32'h7d420474;
   int     clean_tests = 0;
   // Receive words of the last two cycles, newest at index 0
   iq_t    rx_hist [2];

   `include "e300_io_model.svh"

   e300_io_top dut_i (
      .siso_clk2     (siso_clk2),
      .arst_n_i      (arst_n_i),
      .mimo_i        (mimo_i),
      .rx_frame_i    (rx_frame_i),
      .rx_i_i        (rx_word.i),
      .rx_q_i        (rx_word.q),
      .tx_i0_i       (tx0.i),
      .tx_q0_i       (tx0.q),
      .tx_i1_i       (tx1.i),
      .tx_q1_i       (tx1.q),
      .rx_i0_o       (rx_i0_o),
      .rx_q0_o       (rx_q0_o),
      .rx_i1_o       (rx_i1_o),
      .rx_q1_o       (rx_q1_o),
      .tx_i_o        (tx_i_o),
      .tx_q_o        (tx_q_o),
      .radio_en_o    (radio_en_o),
      .tx_frame_hi_o (tx_frame_hi_o),
      .tx_frame_lo_o (tx_frame_lo_o)
   );

   initial begin
      siso_clk2 = 1'b0;
      forever #(clk_period / 2) siso_clk2 = ~siso_clk2;
   end

   // Model follows the DUT registers on every rising edge
   always @(posedge siso_clk2) begin
      if (!arst_n_i) begin
         model_reset();
      end else begin
         model_step(mimo_i, rx_frame_i, rx_word, tx0, tx1);
      end
   end

   // ----------------------------------------------------------
   // Stimulus helpers
   // ----------------------------------------------------------

   // Random sample, zero about one time in four for the SISO fallback
   function automatic sample_t rand_sample();
      logic [31:0] r;
      r = $random(seed);
      if (r[31:30] == 2'b00) begin
         return '0;
      end
      return r[e300_cfg_pkg::sample_width-1:0];
   endfunction

   task automatic drive_inputs(input int kind);
      logic [31:0] r;
      r = $random(seed);
      rx_word = '{i: rand_sample(), q: rand_sample()};
      tx0     = '{i: rand_sample(), q: rand_sample()};
      tx1     = '{i: rand_sample(), q: rand_sample()};
      // SISO ignores the frame bit, MIMO pairs need 1 then 0
      if (kind == siso_rx || kind == siso_tx) begin
         rx_frame_i = r[0];
      end else begin
         rx_frame_i = ~rx_frame_i;
      end
      rx_hist[1] = rx_hist[0];
      rx_hist[0] = rx_word;
   endtask

   // ----------------------------------------------------------
   // Checks
   // ----------------------------------------------------------

   task automatic check_outputs();
      model_expect("rx_i0_o", 32'(m_rx_ch0.i), 32'(rx_i0_o));
      model_expect("rx_q0_o", 32'(m_rx_ch0.q), 32'(rx_q0_o));
      model_expect("rx_i1_o", 32'(m_rx_ch1.i), 32'(rx_i1_o));
      model_expect("rx_q1_o", 32'(m_rx_ch1.q), 32'(rx_q1_o));
      model_expect("tx_i_o", 32'(m_tx_word.i), 32'(tx_i_o));
      model_expect("tx_q_o", 32'(m_tx_word.q), 32'(tx_q_o));
      model_expect("radio_en_o", 32'(model_strobe()), 32'(radio_en_o));
      model_expect("tx_frame_hi_o", 32'(m_strobe_d), 32'(tx_frame_hi_o));
      model_expect("tx_frame_lo_o", 32'(m_strobe_d & m_sync[1]), 32'(tx_frame_lo_o));
   endtask

   // Data and frame outputs held at zero by reset
   task automatic check_zero();
      model_expect("rx_i0_o", 32'd0, 32'(rx_i0_o));
      model_expect("rx_q0_o", 32'd0, 32'(rx_q0_o));
      model_expect("rx_i1_o", 32'd0, 32'(rx_i1_o));
      model_expect("rx_q1_o", 32'd0, 32'(rx_q1_o));
      model_expect("tx_i_o", 32'd0, 32'(tx_i_o));
      model_expect("tx_q_o", 32'd0, 32'(tx_q_o));
      model_expect("tx_frame_hi_o", 32'd0, 32'(tx_frame_hi_o));
      model_expect("tx_frame_lo_o", 32'd0, 32'(tx_frame_lo_o));
   endtask

   // Rules of each test checked straight from the pins, once the mode has settled
   task automatic check_direct(input int kind, input int cycle);
      logic odd_cycle;
      odd_cycle = (cycle % 2) == 1;
      if (kind == siso_rx) begin
         model_expect("radio_en_o", 32'd1, 32'(radio_en_o));
         model_expect("rx_i0_o", 32'(rx_hist[1].i), 32'(rx_i0_o));
         model_expect("rx_i1_o", 32'(rx_hist[1].i), 32'(rx_i1_o));
         model_expect("rx_q0_o", 32'(rx_hist[1].q), 32'(rx_q0_o));
         model_expect("rx_q1_o", 32'(rx_hist[1].q), 32'(rx_q1_o));
      end else if (kind == mimo_rx) begin
         // Mode lands on the second edge after release
         // First MIMO cycle strobes, so strobes fall on odd cycles
         model_expect("radio_en_o", 32'(odd_cycle), 32'(radio_en_o));
      end else if (kind == siso_tx) begin
         // Inputs still hold last cycle's values here
         model_expect("tx_i_o", 32'((tx0.i != '0) ? tx0.i : tx1.i), 32'(tx_i_o));
         model_expect("tx_q_o", 32'((tx0.q != '0) ? tx0.q : tx1.q), 32'(tx_q_o));
         model_expect("tx_frame_hi_o", 32'd1, 32'(tx_frame_hi_o));
         model_expect("tx_frame_lo_o", 32'd0, 32'(tx_frame_lo_o));
      end else if (kind == mimo_tx) begin
         // Both frame halves follow the strobe of the cycle before
         model_expect("tx_frame_hi_o", 32'(!odd_cycle), 32'(tx_frame_hi_o));
         model_expect("tx_frame_lo_o", 32'(!odd_cycle), 32'(tx_frame_lo_o));
      end
   endtask

   // ----------------------------------------------------------
   // Test sequencing
   // ----------------------------------------------------------

   task automatic apply_reset(input logic mode);
      @(negedge siso_clk2);
      arst_n_i   = 1'b0;
      mimo_i     = mode;
      rx_frame_i = 1'b0;
      rx_word    = '0;
      tx0        = '0;
      tx1        = '0;
      rx_hist[0] = '0;
      rx_hist[1] = '0;
      repeat (reset_len) begin
         @(negedge siso_clk2);
         check_zero();
      end
      // Outputs must hold zero until the next rising edge
      arst_n_i = 1'b1;
      check_zero();
   endtask

   task automatic run_test(input string name, input int kind);
      int          errs_before;
      int          hold_left;
      int          c;
      logic [31:0] r;
      errs_before = model_fail_cnt;
      apply_reset(kind == mimo_rx || kind == mimo_tx);
      hold_left = 50;
      for (c = 0; c < test_cycles; c++) begin
         @(negedge siso_clk2);
         check_outputs();
         if (c >= 4) begin
            check_direct(kind, c);
         end
         drive_inputs(kind);
         // Mode flips after a random dwell of 50 to 200 cycles
         if (kind == mode_switch) begin
            hold_left--;
            if (hold_left == 0) begin
               r         = $random(seed);
               mimo_i    = ~mimo_i;
               hold_left = 50 + int'(r % 32'd151);
            end
         end
      end
      if (model_fail_cnt == errs_before) begin
         clean_tests++;
      end
      $display("[TEST] %s done, %0d mismatches", name, model_fail_cnt - errs_before);
   endtask

   // Watchdog, all tests plus a fifth in reserve
   initial begin
      #(num_tests * test_cycles * clk_period * 12 / 10);
      $display("Timeout: the tests did not finish within the expected time");
      $display("test failed");
      $finish;
   end

   initial begin
      arst_n_i   = 1'b0;
      mimo_i     = 1'b0;
      rx_frame_i = 1'b0;
      rx_word    = '0;
      tx0        = '0;
      tx1        = '0;
      model_reset();
      run_test("siso_rx", siso_rx);
      run_test("mimo_rx", mimo_rx);
      run_test("siso_tx", siso_tx);
      run_test("mimo_tx", mimo_tx);
      run_test("mode_switch", mode_switch);
      $display("Summary: %0d tests, %0d clean, %0d with mismatches, %0d mismatches total",
               num_tests, clean_tests, num_tests - clean_tests, model_fail_cnt);
      if (model_fail_cnt == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule : tb_e300_io

`default_nettype wire
